/* files.f */
verilog/gf_pkg.sv
verilog/bch_pkg.sv
verilog/gf_inverter.sv
verilog/syndrome_unit.sv
verilog/bm_serial.sv
verilog/chien_search.sv
verilog/bch_decoder_top.sv
verif/bch_checker.sv
verif/tb_bch_decoder.sv

/* run.sh */
#!/bin/sh
# build and run the BCH decoder testbench, verdict from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bch_decoder \
	-f files.f -o sim_bch \
	&& ./obj_dir/sim_bch > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0

/* verif/tb_bch_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bch_decoder import bch_pkg::*; ();

	localparam int T = 2;
	localparam int dw = $clog2(T + 1);
	localparam int n_table = 22;
	localparam int n_rand = 40;
	localparam int n_frames = n_table + n_rand;
	localparam int timeout_cycles = n_frames * 400; // generous per-frame budget
	localparam logic [8:0] gen_poly = 9'h1d1; // x^8+x^7+x^6+x^4+1

	// message, error mask, expected err_count per row
	localparam logic [code_k-1:0] tbl_msg [n_table] = '{
		7'h00, 7'h5a, 7'h01, 7'h7f, 7'h33, 7'h4c, 7'h12, 7'h6e, 7'h27, 7'h58,
		7'h0f, 7'h70, 7'h2b, 7'h64, 7'h19, 7'h3d, 7'h46, 7'h7f, 7'h00, 7'h55,
		7'h2a, 7'h61};
	localparam logic [code_n-1:0] tbl_mask [n_table] = '{
		15'h0000, 15'h0000, 15'h0001, 15'h0002, 15'h0004, 15'h0008, 15'h0010,
		15'h0020, 15'h0040, 15'h0080, 15'h0100, 15'h0200, 15'h0400, 15'h0800,
		15'h1000, 15'h2000, 15'h4000, 15'h4001, 15'h0003, 15'h6000, 15'h0410,
		15'h2008};
	localparam int tbl_errs [n_table] = '{
		0, 0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 2, 2, 2, 2, 2};

	logic              clk;
	logic              rst_n;
	logic              in_start;
	logic              in_valid;
	logic              in_bit;
	logic              ready;
	logic              out_start;
	logic              out_valid;
	logic              out_bit;
	logic              out_last;
	logic [dw-1:0]     err_count;
	logic              uncorrectable;
	logic              exp_push; // one cycle, with the first bit of each frame
	logic [code_n-1:0] exp_word;
	logic [dw-1:0]     exp_errs;
	int                value_errs;
	int                proto_errs;
	int                frames_seen;
	logic [31:0]       lfsr_state;
	int                cycles = 0;

	// systematic: message on top, remainder of msg*x^8 below
	function automatic logic [code_n-1:0] encode(input logic [code_k-1:0] msg);
		logic [code_n-1:0] rem;
		rem = {msg, 8'b0};
		for (int i = code_n - 1; i >= 8; i--)
			if (rem[i])
				rem = rem ^ (code_n'(gen_poly) << (i - 8)); // cancel top bit
		return {msg, rem[7:0]};
	endfunction

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit
			v = (v << 1) | int'(lfsr_state[0]);
		end
	endtask

	// called on a falling edge, returns on one
	task automatic send_frame(input logic [code_n-1:0] clean, input logic [code_n-1:0] mask,
		input int nerr);
		while (!ready)
			@(negedge clk); // slot still busy
		exp_word = clean;
		exp_errs = dw'(nerr);
		for (int i = code_n - 1; i >= 0; i--) begin
			in_start = (i == code_n - 1);
			exp_push = (i == code_n - 1);
			in_valid = 1'b1;
			in_bit   = clean[i] ^ mask[i]; // msb first
			@(negedge clk);
		end
		in_start = 1'b0;
		in_valid = 1'b0;
		in_bit   = 1'b0;
		exp_push = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	bch_decoder_top #(.T(T)) u_bch_decoder_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_start     (in_start),
		.in_valid     (in_valid),
		.in_bit       (in_bit),
		.ready        (ready),
		.out_start    (out_start),
		.out_valid    (out_valid),
		.out_bit      (out_bit),
		.out_last     (out_last),
		.err_count    (err_count),
		.uncorrectable(uncorrectable)
	);

	bch_checker #(.T(T)) u_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.ready        (ready),
		.out_start    (out_start),
		.out_valid    (out_valid),
		.out_bit      (out_bit),
		.out_last     (out_last),
		.err_count    (err_count),
		.uncorrectable(uncorrectable),
		.exp_push     (exp_push),
		.exp_word     (exp_word),
		.exp_errs     (exp_errs),
		.value_errs   (value_errs),
		.proto_errs   (proto_errs),
		.frames_seen  (frames_seen)
	);

	initial begin
		int v;
		int nerr;
		logic [code_k-1:0] msg;
		logic [code_n-1:0] mask;
		rst_n      = 1'b0;
		in_start   = 1'b0;
		in_valid   = 1'b0;
		in_bit     = 1'b0;
		exp_push   = 1'b0;
		exp_word   = '0;
		exp_errs   = '0;
		lfsr_state = 32'hbc66a1be;
		repeat (10) @(posedge clk); // ten reset cycles
		@(negedge clk);
		rst_n = 1'b1;
		repeat (20) @(negedge clk); // idle, output must stay quiet
		for (int r = 0; r < n_table; r++)
			send_frame(encode(tbl_msg[r]), tbl_mask[r], tbl_errs[r]); // back to back
		for (int r = 0; r < n_rand; r++) begin
			take_bits(code_k, v);
			msg = v[code_k-1:0];
			take_bits(2, v);
			nerr = v % (T + 1); // 0..T errors
			mask = '0;
			while ($countones(mask) < nerr) begin
				take_bits(4, v);
				if (v < code_n)
					mask[v] = 1'b1; // repeats just draw again
			end
			send_frame(encode(msg), mask, nerr);
		end
		while (frames_seen < n_frames)
			@(negedge clk);
		repeat (20) @(negedge clk); // catch stray output
		$display("errors: value %0d, protocol %0d, frames %0d of %0d",
			value_errs, proto_errs, frames_seen, n_frames);
		if (value_errs + proto_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// hard stop
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, %0d of %0d frames handled",
				cycles, frames_seen, n_frames);
			$display("=== FAIL ===");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verif/bch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_checker import bch_pkg::*; #(
	parameter int T = 2
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   ready,
	input  logic                   out_start,
	input  logic                   out_valid,
	input  logic                   out_bit,
	input  logic                   out_last,
	input  logic [$clog2(T+1)-1:0] err_count,
	input  logic                   uncorrectable,
	input  logic                   exp_push,
	input  logic [code_n-1:0]      exp_word,
	input  logic [$clog2(T+1)-1:0] exp_errs,
	output int                     value_errs,
	output int                     proto_errs,
	output int                     frames_seen
);

	localparam int max_wait = 400; // cycles from first input bit to out_start
	localparam int dw = $clog2(T + 1);

	logic [code_n-1:0] word_q [$]; // clean codewords in send order
	logic [dw-1:0]     errs_q [$];
	int                stamp_q [$]; // push time of each frame
	logic [code_n-1:0] got;
	logic [code_n-1:0] cur_word;
	logic [dw-1:0]     cur_errs;
	logic              in_frame = 1'b0;
	logic              check_ready = 1'b0;
	int                idx;
	int                now = 0;

	initial begin
		value_errs  = 0;
		proto_errs  = 0;
		frames_seen = 0;
	end

	always @(posedge clk) begin
		if (rst_n && exp_push) begin
			word_q.push_back(exp_word);
			errs_q.push_back(exp_errs);
			stamp_q.push_back(now);
		end
	end

	// outputs are registered on the rising edge, stable here
	always @(negedge clk) begin
		now = now + 1;
		if (!rst_n) begin
			in_frame    = 1'b0;
			check_ready = 1'b1;
		end else begin
			if (check_ready) begin
				check_ready = 1'b0; // first cycle out of reset
				if (ready !== 1'b1) begin
					value_errs++;
					$display("[FAIL] ready after reset: got %h exp 1", ready);
				end
			end
			if (out_valid) begin
				if (out_start && in_frame) begin
					proto_errs++;
					$display("out_start came in the middle of a frame");
					in_frame = 1'b0;
					frames_seen++;
				end
				if (!in_frame) begin
					if (!out_start) begin
						proto_errs++;
						$display("out_valid high outside a frame without out_start");
					end else if (word_q.size() == 0) begin
						proto_errs++;
						$display("a frame came out while none was expected");
					end else begin
						cur_word = word_q.pop_front();
						cur_errs = errs_q.pop_front();
						void'(stamp_q.pop_front());
						idx      = code_n - 1; // first bit is the top position
						in_frame = 1'b1;
					end
				end
				if (in_frame) begin
					got[idx] = out_bit;
					if (out_last !== (idx == 0)) begin
						value_errs++;
						$display("[FAIL] out_last at bit %0d: got %h exp %h",
							idx, out_last, idx == 0);
					end
					if (idx == 0) begin
						if (got !== cur_word) begin
							value_errs++;
							$display("[FAIL] out_bit frame %0d: got %h exp %h",
								frames_seen, got, cur_word);
						end
						if (err_count !== cur_errs) begin
							value_errs++;
							$display("[FAIL] err_count frame %0d: got %h exp %h",
								frames_seen, err_count, cur_errs);
						end
						if (uncorrectable !== 1'b0) begin
							value_errs++;
							$display("[FAIL] uncorrectable frame %0d: got %h exp 0",
								frames_seen, uncorrectable);
						end
						in_frame = 1'b0;
						frames_seen++;
					end else begin
						idx--;
					end
				end
			end else if (in_frame) begin
				proto_errs++;
				$display("out_valid dropped after %0d of %0d bits", code_n - 1 - idx, code_n);
				in_frame = 1'b0;
				frames_seen++;
			end
			// strobes only ride on valid bits
			if (!out_valid && (out_start || out_last)) begin
				proto_errs++;
				$display("out_start or out_last high while out_valid low");
			end
			// head frame overdue
			if (!in_frame && stamp_q.size() > 0 && now - stamp_q[0] > max_wait) begin
				proto_errs++;
				$display("frame %0d never came out within %0d cycles", frames_seen, max_wait);
				void'(word_q.pop_front());
				void'(errs_q.pop_front());
				void'(stamp_q.pop_front());
				frames_seen++;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/bch_decoder_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_decoder_top import gf_pkg::*, bch_pkg::*; #(
	parameter int T = 2 // correctable errors
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      in_start,
	input  logic                      in_valid,
	input  logic                      in_bit,
	output logic                      ready,
	output logic                      out_start,
	output logic                      out_valid,
	output logic                      out_bit,
	output logic                      out_last,
	output logic [$clog2(T+1)-1:0]    err_count,
	output logic                      uncorrectable
);

	// syndrome -> bm slot
	logic                      syn_valid;
	logic                      syn_take;
	logic [2*T*gf_m-1:0]       syn;
	logic [code_n-1:0]         recv_word;

	// bm -> chien slot
	logic                      sigma_valid;
	logic                      sigma_take;
	logic [(T+1)*gf_m-1:0]     sigma;
	logic [$clog2(T+1)-1:0]    sigma_deg;
	logic [code_n-1:0]         word;

	syndrome_unit #(.T(T)) u_syn (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_start (in_start),
		.in_valid (in_valid),
		.in_bit   (in_bit),
		.ready    (ready),
		.syn_valid(syn_valid),
		.syn      (syn),
		.recv_word(recv_word),
		.syn_take (syn_take)
	);

	bm_serial #(.T(T)) u_bm (
		.clk        (clk),
		.rst_n      (rst_n),
		.syn_valid  (syn_valid),
		.syn        (syn),
		.recv_word  (recv_word),
		.syn_take   (syn_take),
		.sigma_valid(sigma_valid),
		.sigma      (sigma),
		.sigma_deg  (sigma_deg),
		.word       (word),
		.sigma_take (sigma_take)
	);

	chien_search #(.T(T)) u_chien (
		.clk          (clk),
		.rst_n        (rst_n),
		.sigma_valid  (sigma_valid),
		.sigma        (sigma),
		.sigma_deg    (sigma_deg),
		.word         (word),
		.sigma_take   (sigma_take),
		.out_start    (out_start),
		.out_valid    (out_valid),
		.out_bit      (out_bit),
		.out_last     (out_last),
		.err_count    (err_count),
		.uncorrectable(uncorrectable)
	);

endmodule

`default_nettype wire

/* verilog/chien_search.sv */
`timescale 1ns/1ps
`default_nettype none

module chien_search import gf_pkg::*, bch_pkg::*; #(
	parameter int T = 2
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      sigma_valid,
	input  logic [(T+1)*gf_m-1:0]     sigma,
	input  logic [$clog2(T+1)-1:0]    sigma_deg,
	input  logic [code_n-1:0]         word,
	output logic                      sigma_take,
	output logic                      out_start,
	output logic                      out_valid,
	output logic                      out_bit,
	output logic                      out_last,
	output logic [$clog2(T+1)-1:0]    err_count,
	output logic                      uncorrectable
);

	localparam int dw = $clog2(T + 1);
	localparam int cw = $clog2(code_n + 1); // root count, up to code_n
	localparam int pw = $clog2(code_n);

	chien_state_t      state;
	logic              streaming; // second pass, bits going out
	logic [pw-1:0]     pos; // code position under test
	logic [gf_m-1:0]   term [0:T]; // sigma_k * alpha^(k*(n-pos))
	logic [gf_m-1:0]   sum;
	logic              hit; // sigma has a root here
	logic              flip;
	logic              load_terms;
	logic [cw-1:0]     roots;
	logic [dw-1:0]     errs;
	logic              uncorr;
	logic [code_n-1:0] word_r;

	always_comb begin
		sum = '0;
		for (int k = 0; k <= T; k++)
			sum = sum ^ term[k];
	end

	assign hit        = (sum == '0);
	assign flip       = hit && !uncorr; // no flips on a failed frame
	assign load_terms = (state == ch_idle) || sigma_take; // reload for each pass

	always_ff @(posedge clk) begin
		for (int k = 0; k <= T; k++)
			if (load_terms)
				term[k] <= gf_mul(sigma[k*gf_m +: gf_m], gf_alpha_pow(k)); // position n-1
			else
				term[k] <= gf_mul(term[k], gf_alpha_pow(k)); // one position lower
		if (sigma_take)
			word_r <= word;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= ch_idle;
			streaming     <= 1'b0;
			pos           <= '0;
			roots         <= '0;
			errs          <= '0;
			uncorr        <= 1'b0;
			sigma_take    <= 1'b0;
			out_start     <= 1'b0;
			out_valid     <= 1'b0;
			out_bit       <= 1'b0;
			out_last      <= 1'b0;
			err_count     <= '0;
			uncorrectable <= 1'b0;
		end else begin
			sigma_take <= 1'b0;
			out_start  <= 1'b0;
			out_valid  <= 1'b0;
			out_last   <= 1'b0;
			case (state)
				ch_idle: if (sigma_valid) begin
					streaming <= 1'b0; // counting pass on bm's held locator
					pos       <= pw'(code_n - 1);
					roots     <= '0;
					state     <= ch_run;
				end
				ch_run: begin
					if (sigma_take) begin
						streaming <= 1'b1; // setup cycle
						pos       <= pw'(code_n - 1);
						errs      <= '0;
						uncorr    <= (roots != cw'(sigma_deg));
					end else if (!streaming) begin
						roots <= roots + cw'(hit);
						if (pos == '0)
							sigma_take <= 1'b1; // count done, copy frame
						else
							pos <= pos - 1'b1;
					end else begin
						out_valid <= 1'b1;
						out_start <= (pos == pw'(code_n - 1));
						out_bit   <= word_r[pos] ^ flip;
						errs      <= errs + dw'(flip);
						if (pos == '0) begin
							out_last      <= 1'b1;
							err_count     <= errs + dw'(flip);
							uncorrectable <= uncorr;
							state         <= ch_idle;
						end else begin
							pos <= pos - 1'b1;
						end
					end
				end
				default: state <= ch_idle;
			endcase
		end
	end

	// one unbroken burst per frame
	a_out_len: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> out_valid [*code_n] ##1 !out_valid)
		else $error("chien_search: out_valid burst not code_n long");

endmodule

`default_nettype wire

/* verilog/bm_serial.sv */
`timescale 1ns/1ps
`default_nettype none

module bm_serial import gf_pkg::*, bch_pkg::*; #(
	parameter int T = 2
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      syn_valid,
	input  logic [2*T*gf_m-1:0]       syn,
	input  logic [code_n-1:0]         recv_word,
	output logic                      syn_take,
	output logic                      sigma_valid,
	output logic [(T+1)*gf_m-1:0]     sigma,
	output logic [$clog2(T+1)-1:0]    sigma_deg,
	output logic [code_n-1:0]         word,
	input  logic                      sigma_take
);

	localparam int dw = $clog2(T + 1);
	localparam int rw = (T > 1) ? $clog2(T) : 1; // iteration counter
	localparam int iw = $clog2(2 * T); // term counter, 0..2r+1

	bm_state_t       state;
	logic [rw-1:0]   r_cnt;
	logic [iw-1:0]   i_cnt;
	logic [dw-1:0]   u_cnt; // coefficient being updated, counts down
	logic [gf_m-1:0] s_arr [1:2*T]; // captured syndromes
	logic [gf_m-1:0] sig [0:T];
	logic [gf_m-1:0] beta [0:T]; // correction term, already shifted by x^2
	logic [gf_m-1:0] d; // discrepancy
	logic [gf_m-1:0] d_p; // last nonzero discrepancy
	logic [gf_m-1:0] ratio; // d / d_p
	logic [gf_m-1:0] sig_sel;
	logic [gf_m-1:0] syn_sel;
	logic [gf_m-1:0] term;
	logic            last_term;
	logic            grow_now; // degree grows this iteration
	logic            grow;
	logic            inv_start;
	logic            inv_done;
	logic [gf_m-1:0] inv_out;

	// mux sigma_i and S(2r+1-i) for the mac, out of range reads as zero
	always_comb begin
		int s_idx;
		s_idx   = 2 * int'(r_cnt) + 1 - int'(i_cnt);
		sig_sel = '0;
		syn_sel = '0;
		for (int k = 0; k <= T; k++)
			if (int'(i_cnt) == k)
				sig_sel = sig[k];
		for (int j = 1; j <= 2 * T; j++)
			if (s_idx == j)
				syn_sel = s_arr[j];
	end

	assign term      = gf_mul(sig_sel, syn_sel);
	assign last_term = (int'(i_cnt) == 2 * int'(r_cnt) + 1); // S_0 slot, d already final
	assign grow_now  = (d != '0) && (int'(sigma_deg) <= int'(r_cnt));
	assign inv_start = (state == bm_disc) && last_term && (d != '0);

	always_comb begin
		for (int k = 0; k <= T; k++)
			sigma[k*gf_m +: gf_m] = sig[k];
	end

	gf_inverter u_inv (
		.clk      (clk),
		.rst_n    (rst_n),
		.inv_start(inv_start),
		.inv_in   (d_p), // old d_p, captured before it moves
		.inv_done (inv_done),
		.inv_out  (inv_out)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= bm_idle;
			syn_take    <= 1'b0;
			sigma_valid <= 1'b0;
			r_cnt       <= '0;
			i_cnt       <= '0;
			u_cnt       <= '0;
		end else begin
			syn_take <= 1'b0;
			case (state)
				bm_idle: if (syn_valid) begin
					syn_take <= 1'b1; // slot copied this edge
					r_cnt    <= '0;
					i_cnt    <= '0;
					state    <= bm_disc;
				end
				bm_disc: begin
					if (!last_term) begin
						i_cnt <= i_cnt + 1'b1;
					end else if (d != '0) begin
						state <= bm_inv;
					end else if (int'(r_cnt) == T - 1) begin
						sigma_valid <= 1'b1;
						state       <= bm_done_st;
					end else begin
						r_cnt <= r_cnt + 1'b1; // d zero, no update pass
						i_cnt <= '0;
					end
				end
				bm_inv: if (inv_done) begin
					u_cnt <= dw'(T); // top coefficient first
					state <= bm_update;
				end
				bm_update: begin
					if (u_cnt != '0) begin
						u_cnt <= u_cnt - 1'b1;
					end else if (int'(r_cnt) == T - 1) begin
						sigma_valid <= 1'b1;
						state       <= bm_done_st;
					end else begin
						r_cnt <= r_cnt + 1'b1;
						i_cnt <= '0;
						state <= bm_disc;
					end
				end
				bm_done_st: if (sigma_take) begin
					sigma_valid <= 1'b0;
					state       <= bm_idle;
				end
				default: state <= bm_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			bm_idle: if (syn_valid) begin
				for (int j = 1; j <= 2 * T; j++)
					s_arr[j] <= syn[(j-1)*gf_m +: gf_m];
				word <= recv_word;
				for (int k = 0; k <= T; k++) begin
					sig[k]  <= (k == 0) ? gf_m'(1) : '0; // sigma = 1
					beta[k] <= (k == 1) ? gf_m'(1) : '0; // beta = x
				end
				d_p       <= gf_m'(1);
				sigma_deg <= '0;
			end
			bm_disc: begin
				d <= (i_cnt == '0) ? term : d ^ term;
				if (last_term) begin
					grow <= grow_now;
					if (grow_now) begin
						d_p       <= d;
						sigma_deg <= dw'(2 * int'(r_cnt) + 1 - int'(sigma_deg));
					end
					if (d == '0) begin
						for (int k = 2; k <= T; k++)
							beta[k] <= beta[k-2]; // x^2 * beta
						beta[0] <= '0;
						beta[1] <= '0;
					end
				end
			end
			bm_inv: if (inv_done)
				ratio <= gf_mul(d, inv_out);
			bm_update: begin
				// descending, so sig[k-2] and beta[k-2] are still old here
				for (int k = 0; k <= T; k++)
					if (int'(u_cnt) == k)
						sig[k] <= sig[k] ^ gf_mul(ratio, beta[k]);
				for (int k = 2; k <= T; k++)
					if (int'(u_cnt) == k)
						beta[k] <= grow ? sig[k-2] : beta[k-2];
				if (u_cnt == '0) begin
					beta[0] <= '0;
					beta[1] <= '0;
				end
			end
			default: ;
		endcase
	end

	// holds for any frame with at most T errors
	a_deg_bound: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(sigma_valid) |-> int'(sigma_deg) <= T)
		else $error("bm_serial: locator degree above T");

endmodule

`default_nettype wire

/* verilog/syndrome_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module syndrome_unit import gf_pkg::*, bch_pkg::*; #(
	parameter int T = 2
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_start,
	input  logic                  in_valid,
	input  logic                  in_bit,
	output logic                  ready,
	output logic                  syn_valid,
	output logic [2*T*gf_m-1:0]   syn,
	output logic [code_n-1:0]     recv_word,
	input  logic                  syn_take
);

	localparam int cw = $clog2(code_n);

	syn_state_t      state;
	logic [cw-1:0]   bit_cnt;
	logic [gf_m-1:0] acc [1:2*T]; // horner accumulators, acc[j] -> S_j
	logic            take_bit;

	assign ready     = (state == syn_idle); // slot free
	assign syn_valid = (state == syn_full);
	assign take_bit  = in_valid && ((state == syn_idle && in_start) || state == syn_shift);

	always_comb begin
		for (int j = 1; j <= 2 * T; j++)
			syn[(j-1)*gf_m +: gf_m] = acc[j]; // S1 in the low word
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= syn_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				syn_idle: if (in_start && in_valid) begin
					state   <= syn_shift;
					bit_cnt <= cw'(1); // first bit taken with start
				end
				syn_shift: if (in_valid) begin
					if (bit_cnt == cw'(code_n - 1))
						state <= syn_full; // last bit of the frame
					bit_cnt <= bit_cnt + 1'b1;
				end
				syn_full: if (syn_take)
					state <= syn_idle;
				default: state <= syn_idle;
			endcase
		end
	end

	// r(alpha^j) by horner, highest position first
	always_ff @(posedge clk) begin
		if (take_bit) begin
			for (int j = 1; j <= 2 * T; j++)
				acc[j] <= gf_mul(in_start ? '0 : acc[j], gf_alpha_pow(j))
					^ {{(gf_m-1){1'b0}}, in_bit};
			recv_word <= {recv_word[code_n-2:0], in_bit}; // first bit ends at msb
		end
	end

	// source must wait for the slot
	a_start_ready: assert property (@(posedge clk) disable iff (!rst_n)
		in_start |-> ready)
		else $error("syndrome_unit: frame started while ready low");

endmodule

`default_nettype wire

/* verilog/gf_inverter.sv */
`timescale 1ns/1ps
`default_nettype none

module gf_inverter import gf_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            inv_start,
	input  logic [gf_m-1:0] inv_in,
	output logic            inv_done,
	output logic [gf_m-1:0] inv_out
);

	// a^-1 = a^(2^m-2): (m-2) square/multiply pairs, then one last square
	localparam int steps = 2 * gf_m - 3;
	localparam int sw = $clog2(steps + 1);

	logic            busy;
	logic [sw-1:0]   step;
	logic [gf_m-1:0] base; // a, kept for the multiply steps
	logic [gf_m-1:0] acc; // running power

	assign inv_out = acc; // final once done pulses, held until next start

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			step     <= '0;
			inv_done <= 1'b0;
		end else begin
			inv_done <= 1'b0;
			if (inv_start) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				if (step == sw'(steps - 1)) begin
					busy     <= 1'b0;
					inv_done <= 1'b1; // lands 2(m-1) cycles after start
				end
				step <= step + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inv_start) begin
			base <= inv_in;
			acc  <= inv_in;
		end else if (busy) begin
			acc <= step[0] ? gf_mul(acc, base) : gf_mul(acc, acc); // even steps square
		end
	end

	// bm only inverts the last nonzero discrepancy
	a_nonzero_in: assert property (@(posedge clk) disable iff (!rst_n)
		inv_start |-> inv_in != '0)
		else $error("gf_inverter: inverse of zero requested");

endmodule

`default_nettype wire

/* verilog/bch_pkg.sv */
`default_nettype none

package bch_pkg;

	import gf_pkg::*;

	localparam int code_n = gf_n; // full length, no shortening
	localparam int code_k = 7; // message bits for the two-error code

	// syndrome stage, one frame slot
	typedef enum logic [1:0] {
		syn_idle,
		syn_shift,
		syn_full
	} syn_state_t;

	// berlekamp-massey sequencing
	typedef enum logic [2:0] {
		bm_idle,
		bm_disc, // discrepancy mac
		bm_inv, // waiting on inverter
		bm_update, // one locator coefficient per cycle
		bm_done_st // locator held for chien
	} bm_state_t;

	typedef enum logic {
		ch_idle,
		ch_run
	} chien_state_t;

endpackage

`default_nettype wire

/* verilog/gf_pkg.sv */
`default_nettype none

package gf_pkg;

	localparam int gf_m = 4; // bits per field element
	localparam int gf_n = 15; // order of alpha, 2^m - 1
	localparam logic [gf_m-1:0] gf_poly = 4'b0011; // x^4 + x + 1, top term implied

	// shift-and-add product
	// each carry out of the top bit folds back through gf_poly
	function automatic logic [gf_m-1:0] gf_mul(
		input logic [gf_m-1:0] a,
		input logic [gf_m-1:0] b
	);
		logic [gf_m-1:0] acc;
		logic [gf_m-1:0] sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				acc = acc ^ sh; // add a * x^i
			sh = sh[gf_m-1] ? ((sh << 1) ^ gf_poly) : (sh << 1); // times alpha
		end
		return acc;
	endfunction

	// alpha^e, exponent taken mod gf_n
	function automatic logic [gf_m-1:0] gf_alpha_pow(input int e);
		logic [gf_m-1:0] p;
		int k;
		p = gf_m'(1);
		k = e % gf_n;
		if (k < 0)
			k = k + gf_n; // negative exponents wrap
		for (int i = 0; i < gf_n; i++)
			if (i < k)
				p = gf_mul(p, gf_m'(2)); // alpha is x
		return p;
	endfunction

endpackage

`default_nettype wire
